/* src/rvl_pkg.sv */
// shared widths, reset values, opcode and alu enums, and pipeline packets for the rv32 core
package rvl_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // input queue, depth is also the source credit count after reset
    localparam int IBUF_DEPTH = 4;
    localparam int IBUF_PTR_W = $clog2(IBUF_DEPTH);
    localparam int IBUF_CNT_W = $clog2(IBUF_DEPTH + 1);

    localparam int RET_CREDITS = 2;
    localparam int RET_CNT_W   = $clog2(RET_CREDITS + 1);

    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

    // major opcode field, inst[6:0]
    localparam logic [6:0] OPCODE_OP    = 7'b0110011;
    localparam logic [6:0] OPCODE_OPIMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI   = 7'b0110111;

    typedef enum logic [1:0] {
        OPC_OP,
        OPC_OPIMM,
        OPC_LUI,
        OPC_ILLEGAL
    } opc_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASSB // lui result is operand b
    } alu_op_e;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        alu_op_e               alu_op;
        logic [XLEN-1:0]       a;
        logic [XLEN-1:0]       b;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wen;
        logic                  illegal;
    } dec_pkt_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wen;
        logic [XLEN-1:0]       result;
        logic                  illegal;
    } exe_pkt_t;

endpackage

/* src/rvl_wb_if.sv */
// register write-back bus, driven by write-back and seen by the register file and decode
interface rvl_wb_if;
    import rvl_pkg::*;

    logic                  wen;   // one write per retire
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;

    modport wb_mp (
        output wen,
        output waddr,
        output wdata
    );

    modport rf_mp (
        input wen,
        input waddr,
        input wdata
    );

    modport fwd_mp (
        input wen,
        input waddr,
        input wdata
    );

endinterface

/* src/inst_buf.sv */
// input instruction queue, stamps pcs on accepted instructions and returns a credit per pop
module inst_buf (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     in_valid_i,
    input  logic [31:0]              in_inst_i,
    input  logic                     hold_i,
    output logic                     in_credit_o,
    output logic                     head_valid_o,
    output logic [31:0]              head_inst_o,
    output logic [rvl_pkg::XLEN-1:0] head_pc_o
);
    import rvl_pkg::*;

    localparam logic [IBUF_PTR_W-1:0] PTR_LAST = IBUF_PTR_W'(IBUF_DEPTH - 1);

    logic [31:0]           inst_mem_q [IBUF_DEPTH];
    logic [XLEN-1:0]       pc_mem_q   [IBUF_DEPTH];
    logic [IBUF_PTR_W-1:0] wr_ptr_q;
    logic [IBUF_PTR_W-1:0] rd_ptr_q;
    logic [IBUF_CNT_W-1:0] count_q;
    logic [XLEN-1:0]       next_pc_q;
    logic                  pop;

    assign head_valid_o = (count_q != '0);
    assign pop          = head_valid_o && !hold_i;
    assign in_credit_o  = pop; // one credit back per entry released

    assign head_inst_o = inst_mem_q[rd_ptr_q];
    assign head_pc_o   = pc_mem_q[rd_ptr_q];

    // payload storage
    always_ff @(posedge clk) begin
        if (in_valid_i) begin
            inst_mem_q[wr_ptr_q] <= in_inst_i;
            pc_mem_q[wr_ptr_q]   <= next_pc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            count_q   <= '0;
            next_pc_q <= RESET_PC;
        end else begin
            if (in_valid_i) begin
                wr_ptr_q  <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
                next_pc_q <= next_pc_q + XLEN'(4);
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
            end
            // source never writes without a credit, so no overflow
            count_q <= count_q + IBUF_CNT_W'(in_valid_i) - IBUF_CNT_W'(pop);
        end
    end

endmodule

/* src/reg_file.sv */
// architectural register file, two async read ports and the write-back port
module reg_file (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic [rvl_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [rvl_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [rvl_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rvl_pkg::XLEN-1:0]       rs2_data_o,
    rvl_wb_if.rf_mp                        wb
);
    import rvl_pkg::*;

    localparam int NUM_REGS = 1 << REG_ADDR_W;

    logic [XLEN-1:0] regs_q [1:NUM_REGS-1]; // x0 has no storage

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb.wen && wb.waddr != '0) begin
            regs_q[wb.waddr] <= wb.wdata;
        end
    end

endmodule

/* src/id_stage.sv */
// decode stage, builds alu operands with forwarding and registers the decoded packet
module id_stage (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic                           hold_i,
    input  logic                           head_valid_i,
    input  logic [31:0]                    head_inst_i,
    input  logic [rvl_pkg::XLEN-1:0]       head_pc_i,
    output logic [rvl_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [rvl_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [rvl_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [rvl_pkg::XLEN-1:0]       rs2_data_i,
    input  rvl_pkg::exe_pkt_t              ex_fwd_i,
    rvl_wb_if.fwd_mp                       wb_fwd,
    output rvl_pkg::dec_pkt_t              dec_o
);
    import rvl_pkg::*;

    opc_e                  opc;
    alu_op_e               alu_op;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       rs1_val;
    logic [XLEN-1:0]       rs2_val;
    logic [XLEN-1:0]       imm;
    logic                  use_rs1;
    logic                  use_rs2;
    dec_pkt_t              dec_d;
    dec_pkt_t              dec_q;
    logic [REG_ADDR_W-1:0] rs1_q;
    logic [REG_ADDR_W-1:0] rs2_q;
    logic                  use_rs1_q;
    logic                  use_rs2_q;

    assign funct3     = head_inst_i[14:12];
    assign rd         = head_inst_i[11:7];
    assign rs1_addr_o = head_inst_i[19:15];
    assign rs2_addr_o = head_inst_i[24:20];

    // write-back bypass at read time, the ex bypass is applied at the output
    assign rs1_val = (rs1_addr_o == '0) ? '0 :
                     (wb_fwd.wen && wb_fwd.waddr == rs1_addr_o) ? wb_fwd.wdata : rs1_data_i;
    assign rs2_val = (rs2_addr_o == '0) ? '0 :
                     (wb_fwd.wen && wb_fwd.waddr == rs2_addr_o) ? wb_fwd.wdata : rs2_data_i;

    always_comb begin
        case (head_inst_i[6:0])
            OPCODE_OP:    opc = OPC_OP;
            OPCODE_OPIMM: opc = OPC_OPIMM;
            OPCODE_LUI:   opc = OPC_LUI;
            default:      opc = OPC_ILLEGAL;
        endcase

        case (funct3)
            3'b000:  alu_op = (opc == OPC_OP && head_inst_i[30]) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = head_inst_i[30] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
        if (opc == OPC_LUI) alu_op = ALU_PASSB;
        if (opc == OPC_ILLEGAL) alu_op = ALU_ADD;

        if (opc == OPC_LUI) begin
            imm = {head_inst_i[31:12], {(XLEN-20){1'b0}}};
        end else if (funct3 == 3'b001 || funct3 == 3'b101) begin
            imm = {{(XLEN-5){1'b0}}, head_inst_i[24:20]}; // shamt only
        end else begin
            imm = {{(XLEN-12){head_inst_i[31]}}, head_inst_i[31:20]};
        end

        use_rs1 = (opc == OPC_OP) || (opc == OPC_OPIMM);
        use_rs2 = (opc == OPC_OP);

        dec_d         = '0;
        dec_d.valid   = head_valid_i;
        dec_d.pc      = head_pc_i;
        dec_d.alu_op  = alu_op;
        dec_d.a       = use_rs1 ? rs1_val : '0;
        dec_d.b       = use_rs2 ? rs2_val : imm;
        dec_d.rd      = rd;
        dec_d.wen     = (opc != OPC_ILLEGAL) && (rd != '0);
        dec_d.illegal = (opc == OPC_ILLEGAL);
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            dec_q     <= '0;
            use_rs1_q <= 1'b0;
            use_rs2_q <= 1'b0;
        end else if (!hold_i) begin
            dec_q     <= dec_d;
            use_rs1_q <= use_rs1;
            use_rs2_q <= use_rs2;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            rs1_q <= rs1_addr_o;
            rs2_q <= rs2_addr_o;
        end
    end

    // the instruction now in ex is the youngest writer, it wins over the latched value
    always_comb begin
        dec_o = dec_q;
        if (use_rs1_q && ex_fwd_i.valid && ex_fwd_i.wen && ex_fwd_i.rd == rs1_q) begin
            dec_o.a = ex_fwd_i.result;
        end
        if (use_rs2_q && ex_fwd_i.valid && ex_fwd_i.wen && ex_fwd_i.rd == rs2_q) begin
            dec_o.b = ex_fwd_i.result;
        end
    end

endmodule

/* src/ex_stage.sv */
// execute stage, alu on the decoded packet and the execute packet register
module ex_stage (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              hold_i,
    input  rvl_pkg::dec_pkt_t dec_i,
    output rvl_pkg::exe_pkt_t exe_o
);
    import rvl_pkg::*;

    logic [4:0]      shamt;
    logic [XLEN-1:0] alu_res;
    exe_pkt_t        exe_d;
    exe_pkt_t        exe_q;

    assign shamt = dec_i.b[4:0]; // rv32 shifts use 5 bits

    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD:   alu_res = dec_i.a + dec_i.b;
            ALU_SUB:   alu_res = dec_i.a - dec_i.b;
            ALU_AND:   alu_res = dec_i.a & dec_i.b;
            ALU_OR:    alu_res = dec_i.a | dec_i.b;
            ALU_XOR:   alu_res = dec_i.a ^ dec_i.b;
            ALU_SLL:   alu_res = dec_i.a << shamt;
            ALU_SRL:   alu_res = dec_i.a >> shamt;
            ALU_SRA:   alu_res = $unsigned($signed(dec_i.a) >>> shamt);
            ALU_SLT:   alu_res = {{(XLEN-1){1'b0}}, $signed(dec_i.a) < $signed(dec_i.b)};
            ALU_SLTU:  alu_res = {{(XLEN-1){1'b0}}, dec_i.a < dec_i.b};
            ALU_PASSB: alu_res = dec_i.b;
            default:   alu_res = '0;
        endcase
    end

    always_comb begin
        exe_d.valid   = dec_i.valid;
        exe_d.pc      = dec_i.pc;
        exe_d.rd      = dec_i.rd;
        exe_d.wen     = dec_i.wen;
        exe_d.result  = alu_res;
        exe_d.illegal = dec_i.illegal;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            exe_q <= '0;
        end else if (!hold_i) begin
            exe_q <= exe_d;
        end
    end

    assign exe_o = exe_q;

endmodule

/* src/wb_stage.sv */
// write-back and retire, owns the retire credit count and stalls the pipe without a credit
module wb_stage (
    input  logic                           clk,
    input  logic                           rst_i,
    input  rvl_pkg::exe_pkt_t              exe_i,
    input  logic                           ret_credit_i,
    output logic                           hold_o,
    rvl_wb_if.wb_mp                        wb,
    output logic                           ret_valid_o,
    output logic [rvl_pkg::XLEN-1:0]       ret_pc_o,
    output logic [rvl_pkg::REG_ADDR_W-1:0] ret_rd_o,
    output logic                           ret_wen_o,
    output logic [rvl_pkg::XLEN-1:0]       ret_wdata_o,
    output logic                           ret_illegal_o
);
    import rvl_pkg::*;

    logic [RET_CNT_W-1:0] credit_q;
    logic                 credit_ok;
    logic                 retire;

    // a credit returned this cycle can be spent this cycle
    assign credit_ok = (credit_q != '0) || ret_credit_i;
    assign retire    = exe_i.valid && credit_ok;
    assign hold_o    = exe_i.valid && !credit_ok;

    assign ret_valid_o   = retire;
    assign ret_pc_o      = exe_i.pc;
    assign ret_rd_o      = exe_i.rd;
    assign ret_wen_o     = retire && exe_i.wen; // illegal and x0 never write
    assign ret_wdata_o   = exe_i.result;
    assign ret_illegal_o = exe_i.illegal;

    assign wb.wen   = ret_wen_o;
    assign wb.waddr = exe_i.rd;
    assign wb.wdata = exe_i.result;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            credit_q <= RET_CNT_W'(RET_CREDITS);
        end else begin
            credit_q <= credit_q + RET_CNT_W'(ret_credit_i) - RET_CNT_W'(retire);
        end
    end

endmodule

/* src/rvl_core_top.sv */
// top of the rv32 integer pipeline, credit ports on both sides of buffer, decode, execute, retire
module rvl_core_top (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic                           in_valid_i,
    input  logic [31:0]                    in_inst_i,
    output logic                           in_credit_o,
    output logic                           ret_valid_o,
    output logic [rvl_pkg::XLEN-1:0]       ret_pc_o,
    output logic [rvl_pkg::REG_ADDR_W-1:0] ret_rd_o,
    output logic                           ret_wen_o,
    output logic [rvl_pkg::XLEN-1:0]       ret_wdata_o,
    output logic                           ret_illegal_o,
    input  logic                           ret_credit_i
);
    import rvl_pkg::*;

    logic                  hold;     // global stall from retire
    logic                  head_valid;
    logic [31:0]           head_inst;
    logic [XLEN-1:0]       head_pc;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    dec_pkt_t              dec_pkt;
    exe_pkt_t              exe_pkt;

    rvl_wb_if u_wb_if ();

    inst_buf u_inst_buf (
        .clk          (clk),
        .rst_i        (rst_i),
        .in_valid_i   (in_valid_i),
        .in_inst_i    (in_inst_i),
        .hold_i       (hold),
        .in_credit_o  (in_credit_o),
        .head_valid_o (head_valid),
        .head_inst_o  (head_inst),
        .head_pc_o    (head_pc)
    );

    id_stage u_id_stage (
        .clk          (clk),
        .rst_i        (rst_i),
        .hold_i       (hold),
        .head_valid_i (head_valid),
        .head_inst_i  (head_inst),
        .head_pc_i    (head_pc),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .ex_fwd_i     (exe_pkt),  // registered ex result
        .wb_fwd       (u_wb_if.fwd_mp),
        .dec_o        (dec_pkt)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rst_i      (rst_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb         (u_wb_if.rf_mp)
    );

    ex_stage u_ex_stage (
        .clk    (clk),
        .rst_i  (rst_i),
        .hold_i (hold),
        .dec_i  (dec_pkt),
        .exe_o  (exe_pkt)
    );

    wb_stage u_wb_stage (
        .clk           (clk),
        .rst_i         (rst_i),
        .exe_i         (exe_pkt),
        .ret_credit_i  (ret_credit_i),
        .hold_o        (hold),
        .wb            (u_wb_if.wb_mp),
        .ret_valid_o   (ret_valid_o),
        .ret_pc_o      (ret_pc_o),
        .ret_rd_o      (ret_rd_o),
        .ret_wen_o     (ret_wen_o),
        .ret_wdata_o   (ret_wdata_o),
        .ret_illegal_o (ret_illegal_o)
    );

endmodule

/* testbench/tb_props.sv */
// credit and reset assertions, bound into the retire stage and the input buffer
module tb_props #(
    parameter int MAX_LEVEL   = 1,
    parameter int INIT_LEVEL  = 0,
    parameter bit GIVE_BYPASS = 1'b0
) (
    input logic       clk,
    input logic       rst_i,
    input logic       fire_i,  // spends a credit or releases an entry
    input logic       give_i,  // returns a credit or adds an entry
    input logic [7:0] level_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;
    int avail_q; // own count of what may be spent

    always_ff @(posedge clk) begin
        if (rst_i) begin
            avail_q <= INIT_LEVEL;
        end else begin
            avail_q <= avail_q + int'(give_i) - int'(fire_i);
        end
    end

    // a returned credit may count in its own cycle, a new entry only from the next one
    a_fire_needs_credit: assert property (
        @(posedge clk) disable iff (rst_i)
            fire_i |-> (avail_q > 0) || (GIVE_BYPASS && give_i)
    ) else begin
        $error("fired with no credit or entry available");
        fail_cnt++;
    end

    a_level_bounded: assert property (
        @(posedge clk) disable iff (rst_i) level_i <= 8'(MAX_LEVEL)
    ) else begin
        $error("counter above its limit");
        fail_cnt++;
    end

    // second reset cycle onward, the registers are already cleared
    a_quiet_in_reset: assert property (
        @(posedge clk) (rst_i && $past(rst_i)) |-> !fire_i
    ) else begin
        $error("output pulse during reset");
        fail_cnt++;
    end

endmodule

bind wb_stage tb_props #(
    .MAX_LEVEL   (rvl_pkg::RET_CREDITS),
    .INIT_LEVEL  (rvl_pkg::RET_CREDITS),
    .GIVE_BYPASS (1'b1)
) u_ret_props (
    .clk     (clk),
    .rst_i   (rst_i),
    .fire_i  (ret_valid_o),
    .give_i  (ret_credit_i),
    .level_i (8'(credit_q))
);

bind inst_buf tb_props #(
    .MAX_LEVEL   (rvl_pkg::IBUF_DEPTH),
    .INIT_LEVEL  (0),
    .GIVE_BYPASS (1'b0)
) u_buf_props (
    .clk     (clk),
    .rst_i   (rst_i),
    .fire_i  (in_credit_o),
    .give_i  (in_valid_i),
    .level_i (8'(count_q))
);

/* testbench/tb_checker.sv */
// testbench checker, register model of the rv32 integer ops compared with every retirement
module tb_checker #(
    parameter int NUM_INSTS = 1
) (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        in_valid_i,
    input  logic [31:0] in_inst_i,
    input  logic        in_credit_i,
    input  logic        ret_valid_i,
    input  logic [31:0] ret_pc_i,
    input  logic [4:0]  ret_rd_i,
    input  logic        ret_wen_i,
    input  logic [31:0] ret_wdata_i,
    input  logic        ret_illegal_i,
    output int          retired_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import rvl_pkg::*;

    logic [31:0] model_regs [32];
    logic [31:0] pending [$]; // accepted, not yet retired
    int          src_credits;
    int          val_errs = 0;
    int          proto_errs = 0;
    logic [31:0] exp_inst;
    logic [31:0] exp_res;
    logic        exp_wen;
    logic        exp_ill;

    // architectural result of one instruction on the model registers
    function automatic void model_exec(input logic [31:0] inst, output logic [31:0] res,
                                       output logic wen, output logic illegal);
        logic [31:0] a;
        logic [31:0] b;
        logic        alt;
        a = model_regs[inst[19:15]];
        b = model_regs[inst[24:20]];
        alt = 1'b0;
        res = '0;
        illegal = 1'b0;
        if (inst[6:0] == OPCODE_LUI) begin
            res = {inst[31:12], 12'h000};
        end else if (inst[6:0] == OPCODE_OP || inst[6:0] == OPCODE_OPIMM) begin
            if (inst[6:0] == OPCODE_OP) begin
                alt = inst[30];
            end else begin
                b = {{20{inst[31]}}, inst[31:20]};
                alt = (inst[14:12] == 3'b101) && inst[30]; // srai only, no subi
            end
            case (inst[14:12])
                3'b000:  res = alt ? a - b : a + b;
                3'b001:  res = a << b[4:0];
                3'b010:  res = {31'b0, $signed(a) < $signed(b)};
                3'b011:  res = {31'b0, a < b};
                3'b100:  res = a ^ b;
                3'b101:  res = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'b110:  res = a | b;
                default: res = a & b;
            endcase
        end else begin
            illegal = 1'b1;
        end
        wen = !illegal && inst[11:7] != 5'd0;
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERR %s expected 0x%08h actual 0x%08h at instruction %0d",
                     name, exp, act, retired_o);
            val_errs++;
        end
    endtask

    task automatic check_retire();
        if (pending.size() == 0) begin
            $display("retirement seen with no accepted instruction outstanding");
            proto_errs++;
            return;
        end
        exp_inst = pending.pop_front();
        model_exec(exp_inst, exp_res, exp_wen, exp_ill);
        check_field("ret_pc_o", RESET_PC + 32'(4 * retired_o), ret_pc_i);
        check_field("ret_illegal_o", 32'(exp_ill), 32'(ret_illegal_i));
        check_field("ret_wen_o", 32'(exp_wen), 32'(ret_wen_i));
        if (!exp_ill) begin
            check_field("ret_rd_o", 32'(exp_inst[11:7]), 32'(ret_rd_i));
        end
        if (exp_wen) begin
            check_field("ret_wdata_o", exp_res, ret_wdata_i);
            model_regs[exp_inst[11:7]] = exp_res;
        end
        retired_o++;
    endtask

    // mid-cycle sampling, inputs move 2 ns after the edge
    always @(negedge clk) begin
        if (rst_i) begin
            for (int r = 0; r < 32; r++) begin
                model_regs[r] = '0;
            end
            pending.delete();
            src_credits = IBUF_DEPTH;
            retired_o = 0;
        end else begin
            if (in_valid_i) begin
                if (src_credits == 0) begin
                    $display("source sent an instruction without holding an input credit");
                    proto_errs++;
                end
                src_credits--;
                pending.push_back(in_inst_i);
            end
            if (in_credit_i) src_credits++;
            if (src_credits > IBUF_DEPTH) begin
                $display("input credits returned beyond the buffer depth, count %0d", src_credits);
                proto_errs++;
                src_credits = IBUF_DEPTH;
            end
            if (ret_valid_i) check_retire();
        end
    end

    task automatic summarize(input int prop_fails, output int total);
        if (pending.size() != 0) begin
            $display("%0d accepted instructions never retired", pending.size());
            proto_errs++;
        end
        if (src_credits != IBUF_DEPTH) begin
            $display("source ended with %0d input credits instead of all of them", src_credits);
            proto_errs++;
        end
        if (retired_o != NUM_INSTS) begin
            $display("retired count differs from the number of instructions sent");
            proto_errs++;
        end
        $display("errors: value %0d, protocol %0d, assertion %0d, retired %0d of %0d",
                 val_errs, proto_errs, prop_fails, retired_o, NUM_INSTS);
        total = val_errs + proto_errs + prop_fails;
    endtask

endmodule

/* testbench/tb_top.sv */
// testbench top, streams lfsr-built rv32 instructions through the core under credit flow control
module tb_top;
    timeunit 1ns;
    timeprecision 100ps;
    import rvl_pkg::*;

    localparam int          NUM_INSTS  = 400;
    localparam logic [15:0] LFSR_SEED  = 16'd22531;
    localparam logic [15:0] LFSR_TAPS  = 16'hB400; // x^16 + x^14 + x^13 + x^11 + 1
    localparam int          CLK_PERIOD = 40;
    localparam int          DRV_DELAY  = 2;
    localparam int          RST_CYCLES = 2;
    localparam longint      TIMEOUT_NS = longint'(NUM_INSTS * 10 + RST_CYCLES) * CLK_PERIOD;

    logic        clk = 1'b0;
    logic        rst_i;
    logic        in_valid_i;
    logic [31:0] in_inst_i;
    logic        in_credit_o;
    logic        ret_valid_o;
    logic [31:0] ret_pc_o;
    logic [4:0]  ret_rd_o;
    logic        ret_wen_o;
    logic [31:0] ret_wdata_o;
    logic        ret_illegal_o;
    logic        ret_credit_i;

    logic [15:0] lfsr_q;
    logic [31:0] prog [NUM_INSTS];
    int          send_idx;
    int          src_credits;  // input credits held by the source
    int          owed_credits; // retire credits the sink still has to return
    int          sink_wait;
    int          retired;
    int          prop_fails;
    int          total_errs;

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [4:0] pick_reg();
        if (rand_bits(2) == 0) return 5'(rand_bits(5));
        return 5'(rand_bits(3)); // mostly x0..x7, lots of dependences
    endfunction

    function automatic logic [31:0] gen_inst();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [6:0]  opcode;
        logic [11:0] imm;
        logic [2:0]  cls;
        rd = pick_reg();
        rs1 = pick_reg();
        rs2 = pick_reg();
        f3 = 3'(rand_bits(3));
        alt = rand_bits(1) != 0;
        if (rand_bits(8) < 13) begin // about 5% illegal
            opcode = 7'(rand_bits(7));
            if (opcode == OPCODE_OP || opcode == OPCODE_OPIMM || opcode == OPCODE_LUI) begin
                opcode = opcode ^ 7'h40;
            end
            return {25'(rand_bits(25)), opcode};
        end
        cls = 3'(rand_bits(3));
        if (cls < 4) begin
            return {1'b0, alt && (f3 == 3'b000 || f3 == 3'b101), 5'b0, rs2, rs1, f3, rd, OPCODE_OP};
        end else if (cls < 7) begin
            imm = 12'(rand_bits(12));
            if (f3 == 3'b001) imm[11:5] = 7'h00;
            if (f3 == 3'b101) imm[11:5] = alt ? 7'h20 : 7'h00;
            return {imm, rs1, f3, rd, OPCODE_OPIMM};
        end
        return {20'(rand_bits(20)), rd, OPCODE_LUI};
    endfunction

    task automatic drive_source();
        in_valid_i = 1'b0;
        if (send_idx < NUM_INSTS && src_credits > 0 && rand_bits(2) != 0) begin
            in_valid_i = 1'b1;
            in_inst_i = prog[send_idx];
            send_idx++;
            src_credits--;
        end
    endtask

    // each credit goes back after 0 to 3 cycles
    task automatic drive_sink();
        ret_credit_i = 1'b0;
        if (owed_credits > 0) begin
            if (sink_wait == 0) begin
                ret_credit_i = 1'b1;
                owed_credits--;
                sink_wait = int'(rand_bits(2));
            end else begin
                sink_wait--;
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst_i) begin
            if (in_credit_o) src_credits++;
            if (ret_valid_o) owed_credits++;
        end
    end

    initial begin
        rst_i = 1'b1;
        in_valid_i = 1'b0;
        in_inst_i = '0;
        ret_credit_i = 1'b0;
        lfsr_q = LFSR_SEED;
        send_idx = 0;
        src_credits = IBUF_DEPTH;
        owed_credits = 0;
        sink_wait = 0;
        for (int n = 0; n < NUM_INSTS; n++) begin
            prog[n] = gen_inst();
        end
        repeat (RST_CYCLES) @(posedge clk);
        #DRV_DELAY rst_i = 1'b0;
        forever begin
            @(posedge clk);
            #DRV_DELAY;
            drive_source();
            drive_sink();
        end
    end

    initial begin
        wait (rst_i === 1'b0);
        wait (retired == NUM_INSTS);
        repeat (4) @(posedge clk);
        prop_fails = i_rvl_core_top.u_wb_stage.u_ret_props.fail_cnt
                   + i_rvl_core_top.u_inst_buf.u_buf_props.fail_cnt;
        i_checker.summarize(prop_fails, total_errs);
        if (total_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired with %0d of %0d instructions retired", retired, NUM_INSTS);
        $display("sim failed");
        $finish;
    end

    rvl_core_top i_rvl_core_top (
        .clk           (clk),
        .rst_i         (rst_i),
        .in_valid_i    (in_valid_i),
        .in_inst_i     (in_inst_i),
        .in_credit_o   (in_credit_o),
        .ret_valid_o   (ret_valid_o),
        .ret_pc_o      (ret_pc_o),
        .ret_rd_o      (ret_rd_o),
        .ret_wen_o     (ret_wen_o),
        .ret_wdata_o   (ret_wdata_o),
        .ret_illegal_o (ret_illegal_o),
        .ret_credit_i  (ret_credit_i)
    );

    tb_checker #(.NUM_INSTS(NUM_INSTS)) i_checker (
        .clk           (clk),
        .rst_i         (rst_i),
        .in_valid_i    (in_valid_i),
        .in_inst_i     (in_inst_i),
        .in_credit_i   (in_credit_o),
        .ret_valid_i   (ret_valid_o),
        .ret_pc_i      (ret_pc_o),
        .ret_rd_i      (ret_rd_o),
        .ret_wen_i     (ret_wen_o),
        .ret_wdata_i   (ret_wdata_o),
        .ret_illegal_i (ret_illegal_o),
        .retired_o     (retired)
    );

endmodule

/* verilog.f */
src/rvl_pkg.sv
src/rvl_wb_if.sv
src/inst_buf.sv
src/reg_file.sv
src/id_stage.sv
src/ex_stage.sv
src/wb_stage.sv
src/rvl_core_top.sv
testbench/tb_props.sv
testbench/tb_checker.sv
testbench/tb_top.sv
